//--- Bender.yml
package:
  name: dual_stream_merge

export_include_dirs:
  - common

sources:
  - files:
      - common/stream_pkg.sv
      - common/axis_if.sv
      - axis_fifo/axis_minimal_fifo.sv
      - axis_fifo/axis_fifo_ram.sv
      - axis_fifo/axis_fifo.sv
      - hdl/stream_merge.sv
      - hdl/dual_stream_merge_top.sv

  - target: test
    files:
      - sim/stream_merge_properties.sv
      - sim/dual_stream_merge_tb.sv

//--- axis_fifo/axis_fifo.sv
/*
 * Stream FIFO wrapper
 * Picks the implementation from the requested depth (2^SIZE):
 * SIZE of 1 gives the two-entry register FIFO, larger sizes the
 * RAM-based circular FIFO. SIZE of 0 is rejected.
 */

`timescale 1ns/100ps

module axis_fifo #(
    parameter int  SIZE      = 4,
    parameter type payload_t = logic
) (
    input  logic        clk,
    input  logic        reset,
    axis_if.snk         in,
    axis_if.src         out,
    output logic [SIZE:0] occupied
);

    generate
        if (SIZE == 0)
        begin : g_unsupported
            $fatal(1, "axis_fifo: SIZE of 0 is not supported");
        end
        else if (SIZE <= 1)
        begin : g_minimal
            logic [1:0] min_occupied;

            // Two flop stages, breaks paths between the two sides
            axis_minimal_fifo #(
                .payload_t (payload_t)
            ) minimal_fifo_i (
                .clk      (clk),
                .reset    (reset),
                .in       (in),
                .out      (out),
                .occupied (min_occupied)
            );

            // Widen to the wrapper's count width
            assign occupied = (SIZE+1)'(min_occupied);
        end
        else
        begin : g_ram
            // Deeper buffers go to an inferred memory
            axis_fifo_ram #(
                .SIZE      (SIZE),
                .payload_t (payload_t)
            ) ram_fifo_i (
                .clk      (clk),
                .reset    (reset),
                .in       (in),
                .out      (out),
                .occupied (occupied)
            );
        end
    endgenerate

endmodule

//--- axis_fifo/axis_fifo_ram.sv
/*
 * RAM-based circular FIFO
 * 2^SIZE entries in an inferred memory, followed by a prefetch
 * register that feeds the output. The prefetch register reloads on
 * the edge its beat leaves, so reads run at full rate.
 */

`timescale 1ns/100ps

module axis_fifo_ram #(
    parameter int  SIZE      = 4,
    parameter type payload_t = logic
) (
    input  logic          clk,
    input  logic          reset,
    axis_if.snk           in,
    axis_if.src           out,
    output logic [SIZE:0] occupied
);

    localparam int DEPTH = 2 ** SIZE;

    payload_t        mem [DEPTH];
    logic [SIZE-1:0] wr_ptr;
    logic [SIZE-1:0] rd_ptr;
    // Beats held in memory, prefetch register excluded
    logic [SIZE:0]   mem_count;
    payload_t        out_data_q;
    logic            out_valid_q;

    logic push;
    logic pop;
    logic load;
    logic mem_empty;
    logic wr_mem;
    logic rd_mem;

    assign push      = in.tvalid && in.tready;
    assign pop       = out_valid_q && out.tready;
    // Prefetch slot free now or freed on this edge
    assign load      = !out_valid_q || pop;
    assign mem_empty = (mem_count == '0);
    // Empty memory with free slot, beat skips the RAM
    assign wr_mem    = push && !(load && mem_empty);
    assign rd_mem    = load && !mem_empty;

    // Total count covers memory and prefetch register
    assign occupied   = mem_count + (SIZE+1)'(out_valid_q);
    assign in.tready  = (occupied < (SIZE+1)'(DEPTH));
    assign out.tvalid = out_valid_q;
    assign out.tdata  = out_data_q;

    // ------------------------------------------------------------------------
    // Pointers and counters
    // ------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            mem_count   <= '0;
            out_valid_q <= 1'b0;
        end
        else
        begin
            if (wr_mem)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_mem)
                rd_ptr <= rd_ptr + 1'b1;
            if (wr_mem && !rd_mem)
                mem_count <= mem_count + 1'b1;
            else if (rd_mem && !wr_mem)
                mem_count <= mem_count - 1'b1;
            // Output stays valid while there is something to offer
            if (load)
                out_valid_q <= rd_mem || push;
        end
    end

    // ------------------------------------------------------------------------
    // Memory and prefetch data
    // ------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (wr_mem)
            mem[wr_ptr] <= in.tdata;
        // Oldest beat from memory first, else bypass
        if (rd_mem)
            out_data_q <= mem[rd_ptr];
        else if (load && push)
            out_data_q <= in.tdata;
    end

endmodule

//--- axis_fifo/axis_minimal_fifo.sv
/*
 * Two-entry register FIFO
 * Both sides are driven from flops only, so no combinational path
 * runs from out.tready to in.tready. Reports its fill count.
 */

`timescale 1ns/100ps

module axis_minimal_fifo #(
    parameter type payload_t = logic
) (
    input  logic       clk,
    input  logic       reset,
    axis_if.snk        in,
    axis_if.src        out,
    output logic [1:0] occupied
);

    // ------------------------------------------------------------------------
    // Storage and pointers
    // ------------------------------------------------------------------------

    payload_t   entry [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    // Transfers on each side
    assign push = in.tvalid && in.tready;
    assign pop  = out.tvalid && out.tready;

    // Full at two entries
    assign in.tready  = (count != 2'd2);
    assign out.tvalid = (count != 2'd0);
    assign out.tdata  = entry[rd_ptr];
    assign occupied   = count;

    // ------------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end
        else
        begin
            if (push)
                wr_ptr <= ~wr_ptr;
            if (pop)
                rd_ptr <= ~rd_ptr;
            // Count only moves when one side transfers alone
            if (push && !pop)
                count <= count + 2'd1;
            else if (pop && !push)
                count <= count - 2'd1;
        end
    end

    // Payload flops
    always_ff @(posedge clk)
    begin
        if (push)
            entry[wr_ptr] <= in.tdata;
    end

endmodule

//--- common/axis_if.sv
/*
 * AXI-Stream style interface
 * Valid/ready handshake with a payload of any packed type
 */

`timescale 1ns/100ps

interface axis_if #(
    parameter type payload_t = logic
) (
    input logic clk
);

    payload_t tdata;
    logic     tvalid;
    logic     tready;

    // Producer side
    modport src (
        input  clk,
        output tdata,
        output tvalid,
        input  tready
    );

    // Consumer side
    modport snk (
        input  clk,
        input  tdata,
        input  tvalid,
        output tready
    );

endinterface

//--- common/stream_cfg.svh
/*
 * Stream merger configuration
 * Data beat width and the buffer depth of each input lane, as log2
 */

`ifndef STREAM_CFG_SVH
`define STREAM_CFG_SVH

// Width of one data beat
`define STREAM_DATA_WIDTH 32
// Lane 0 uses the two-entry register FIFO
`define LANE0_FIFO_SIZE 1
// Lane 1 uses a 16-entry RAM FIFO
`define LANE1_FIFO_SIZE 4

`endif

//--- common/stream_pkg.sv
/*
 * Stream merger types
 * Beat layouts of the input lanes and of the merged output stream
 */

package stream_pkg;

`include "stream_cfg.svh"

    // One beat on an input lane, also the FIFO payload
    typedef struct packed {
        logic [`STREAM_DATA_WIDTH-1:0] data;
        logic                          last;
    } lane_beat_t;

    // Merged beat, tagged with the lane it came from
    typedef struct packed {
        logic       src;
        lane_beat_t beat;
    } merged_beat_t;

endpackage

//--- flist.f
+incdir+common
common/stream_pkg.sv
common/axis_if.sv
axis_fifo/axis_minimal_fifo.sv
axis_fifo/axis_fifo_ram.sv
axis_fifo/axis_fifo.sv
hdl/stream_merge.sv
hdl/dual_stream_merge_top.sv
sim/stream_merge_properties.sv
sim/dual_stream_merge_tb.sv

//--- hdl/dual_stream_merge_top.sv
/*
 * Dual stream merger, top level
 * Buffers each input lane in its own FIFO and merges both lanes
 * packet by packet into one tagged output stream.
 */

`timescale 1ns/100ps

`include "stream_cfg.svh"

module dual_stream_merge_top
    import stream_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,
    // Lane 0 input
    input  logic [`STREAM_DATA_WIDTH-1:0] in0_data,
    input  logic                          in0_last,
    input  logic                          in0_valid,
    output logic                          in0_ready,
    // Lane 1 input
    input  logic [`STREAM_DATA_WIDTH-1:0] in1_data,
    input  logic                          in1_last,
    input  logic                          in1_valid,
    output logic                          in1_ready,
    // Merged output
    output logic [`STREAM_DATA_WIDTH-1:0] out_data,
    output logic                          out_last,
    output logic                          out_src,
    output logic                          out_valid,
    input  logic                          out_ready,
    // FIFO fill levels
    output logic [`LANE0_FIFO_SIZE:0]     lane0_level,
    output logic [`LANE1_FIFO_SIZE:0]     lane1_level
);

    axis_if #(.payload_t(lane_beat_t))   lane0_in   (.clk(clk));
    axis_if #(.payload_t(lane_beat_t))   lane0_out  (.clk(clk));
    axis_if #(.payload_t(lane_beat_t))   lane1_in   (.clk(clk));
    axis_if #(.payload_t(lane_beat_t))   lane1_out  (.clk(clk));
    axis_if #(.payload_t(merged_beat_t)) merged_out (.clk(clk));

    // Plain ports onto the lane streams
    assign lane0_in.tdata  = '{data: in0_data, last: in0_last};
    assign lane0_in.tvalid = in0_valid;
    assign in0_ready       = lane0_in.tready;
    assign lane1_in.tdata  = '{data: in1_data, last: in1_last};
    assign lane1_in.tvalid = in1_valid;
    assign in1_ready       = lane1_in.tready;

    // Small lane buffer
    axis_fifo #(.SIZE(`LANE0_FIFO_SIZE), .payload_t(lane_beat_t)) fifo_lane0_i (
        .clk(clk), .reset(reset), .in(lane0_in), .out(lane0_out), .occupied(lane0_level)
    );

    // Deep lane buffer
    axis_fifo #(.SIZE(`LANE1_FIFO_SIZE), .payload_t(lane_beat_t)) fifo_lane1_i (
        .clk(clk), .reset(reset), .in(lane1_in), .out(lane1_out), .occupied(lane1_level)
    );

    stream_merge merge_i (
        .clk(clk), .reset(reset), .lane0(lane0_out), .lane1(lane1_out), .merged(merged_out)
    );

    // Merged stream back to plain ports
    assign out_data          = merged_out.tdata.beat.data;
    assign out_last          = merged_out.tdata.beat.last;
    assign out_src           = merged_out.tdata.src;
    assign out_valid         = merged_out.tvalid;
    assign merged_out.tready = out_ready;

endmodule

//--- hdl/stream_merge.sv
/*
 * Two-lane packet merger
 * Round-robin between lanes at packet boundaries only; a granted lane
 * keeps the grant until its last beat. Each beat is tagged with its
 * lane and goes through one output register.
 */

`timescale 1ns/100ps

module stream_merge
    import stream_pkg::*;
(
    input  logic clk,
    input  logic reset,
    axis_if.snk  lane0,
    axis_if.snk  lane1,
    axis_if.src  merged
);

    // Packet in flight and its lane
    logic         grant_active;
    logic         grant_lane;
    // Lane favored at the next boundary
    logic         rr_lane;
    merged_beat_t out_beat_q;
    logic         out_valid_q;

    logic       sel;
    logic       sel_valid;
    lane_beat_t sel_beat;
    logic       load_ok;
    logic       take;

    // ------------------------------------------------------------------------
    // Lane selection
    // ------------------------------------------------------------------------

    always_comb
    begin
        if (grant_active)
            sel = grant_lane;
        else if (rr_lane ? lane1.tvalid : lane0.tvalid)
            sel = rr_lane;
        else
            sel = ~rr_lane;
    end

    assign sel_valid = sel ? lane1.tvalid : lane0.tvalid;
    assign sel_beat  = sel ? lane1.tdata : lane0.tdata;

    // Output register free or emptying this cycle
    assign load_ok = !out_valid_q || merged.tready;
    assign take    = load_ok && sel_valid;

    // Only the selected lane sees ready
    assign lane0.tready = load_ok && !sel;
    assign lane1.tready = load_ok && sel;

    assign merged.tvalid = out_valid_q;
    assign merged.tdata  = out_beat_q;

    // ------------------------------------------------------------------------
    // Grant and output stage
    // ------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            grant_active <= 1'b0;
            grant_lane   <= 1'b0;
            rr_lane      <= 1'b0;
            out_valid_q  <= 1'b0;
        end
        else if (take)
        begin
            out_valid_q <= 1'b1;
            if (sel_beat.last)
            begin
                // Packet done, other lane goes first next time
                grant_active <= 1'b0;
                rr_lane      <= ~sel;
            end
            else
            begin
                grant_active <= 1'b1;
                grant_lane   <= sel;
            end
        end
        else if (merged.tready)
            out_valid_q <= 1'b0;
    end

    // Tagged beat, payload only
    always_ff @(posedge clk)
    begin
        if (take)
            out_beat_q <= '{src: sel, beat: sel_beat};
    end

endmodule

//--- sim/dual_stream_merge_tb.sv
/*
 * Dual stream merger testbench
 * Random packets on both lanes, random output stalls, per-lane
 * expected queues, packet atomicity and round-robin checks
 */

`timescale 1ns/100ps

`include "stream_cfg.svh"

module dual_stream_merge_tb
    import stream_pkg::*;
();

    localparam int PACKETS = 40;
    // Leading packets per lane sent back to back
    localparam int GAPLESS = 12;
    // Output packets that must alternate between lanes
    localparam int ALT_PACKETS = 16;

    logic                          clk;
    logic                          reset;
    logic [`STREAM_DATA_WIDTH-1:0] in0_data;
    logic                          in0_last;
    logic                          in0_valid;
    logic                          in0_ready;
    logic [`STREAM_DATA_WIDTH-1:0] in1_data;
    logic                          in1_last;
    logic                          in1_valid;
    logic                          in1_ready;
    logic [`STREAM_DATA_WIDTH-1:0] out_data;
    logic                          out_last;
    logic                          out_src;
    logic                          out_valid;
    logic                          out_ready;
    logic [`LANE0_FIFO_SIZE:0]     lane0_level;
    logic [`LANE1_FIFO_SIZE:0]     lane1_level;

    // Per-lane stimulus beats, idle cycles before each beat and expected beats
    lane_beat_t   stim_beats [2][$];
    int           stim_gap   [2][$];
    merged_beat_t exp_beats  [2][$];
    int           total_beats    = 0;
    int           timeout_cycles = 0;
    logic         stim_built     = 1'b0;

    // Output packet tracking
    logic in_packet = 1'b0;
    logic pkt_src   = 1'b0;
    logic prev_src  = 1'b0;
    int   pkt_count = 0;

    dual_stream_merge_top dual_stream_merge_top_i (
        .clk(clk), .reset(reset),
        .in0_data(in0_data), .in0_last(in0_last), .in0_valid(in0_valid), .in0_ready(in0_ready),
        .in1_data(in1_data), .in1_last(in1_last), .in1_valid(in1_valid), .in1_ready(in1_ready),
        .out_data(out_data), .out_last(out_last), .out_src(out_src),
        .out_valid(out_valid), .out_ready(out_ready),
        .lane0_level(lane0_level), .lane1_level(lane1_level)
    );

    always #50 clk = ~clk;

    // ------------------------------------------------------------------------
    // Reference model and checks
    // ------------------------------------------------------------------------

    // Beat as it must leave the merger, tagged with its lane
    function automatic merged_beat_t expected_beat(input int lane, input lane_beat_t beat);
        merged_beat_t result;
        result.src  = lane[0];
        result.beat = beat;
        return result;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    // Lane tag is covered by the queue choice, so payload fields only
    task automatic check_beat(input merged_beat_t got, input merged_beat_t exp);
        if (got.beat.data !== exp.beat.data)
            abort_run($sformatf("ERR out_data: got 0x%h expected 0x%h",
                                got.beat.data, exp.beat.data));
        if (got.beat.last !== exp.beat.last)
            abort_run($sformatf("ERR out_last: got 0x%h expected 0x%h",
                                got.beat.last, exp.beat.last));
    endtask

    task automatic check_level(input string name, input logic [`LANE1_FIFO_SIZE:0] level,
                               input int limit);
        if (level > limit)
            abort_run($sformatf("ERR %s: got 0x%h above limit 0x%h", name, level, limit));
    endtask

    task automatic check_src(input logic got, input logic exp, input string rule);
        if (got !== exp)
            abort_run($sformatf("ERR out_src: got 0x%h expected 0x%h (%s)", got, exp, rule));
    endtask

    // One output transfer against the queue of its lane
    task automatic handle_output(input merged_beat_t got);
        merged_beat_t exp;
        if (in_packet)
            check_src(got.src, pkt_src, "packets interleaved");
        else if (pkt_count > 0 && pkt_count < ALT_PACKETS)
            check_src(got.src, ~prev_src, "round-robin order");
        if (exp_beats[got.src].size() == 0)
            abort_run($sformatf("Beat from lane %0d arrived with none pending", got.src));
        exp = exp_beats[got.src].pop_front();
        check_beat(got, exp);
        if (!in_packet)
        begin
            in_packet = 1'b1;
            pkt_src   = got.src;
        end
        if (got.beat.last)
        begin
            in_packet = 1'b0;
            prev_src  = got.src;
            pkt_count++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Lane drivers
    // ------------------------------------------------------------------------

    task automatic set_lane(input int lane, input lane_beat_t beat, input logic valid);
        if (lane == 0)
        begin
            in0_data  = beat.data;
            in0_last  = beat.last;
            in0_valid = valid;
        end
        else
        begin
            in1_data  = beat.data;
            in1_last  = beat.last;
            in1_valid = valid;
        end
    endtask

    // Runs from a falling edge where ready depends on FIFO flops only
    task automatic send_packets(input int lane);
        int   idx;
        logic accepted;
        logic ready_now;
        for (idx = 0; idx < stim_beats[lane].size(); idx++)
        begin
            if (stim_gap[lane][idx] > 0)
            begin
                set_lane(lane, '0, 1'b0);
                repeat (stim_gap[lane][idx]) @(negedge clk);
            end
            set_lane(lane, stim_beats[lane][idx], 1'b1);
            accepted = 1'b0;
            while (!accepted)
            begin
                ready_now = (lane == 0) ? in0_ready : in1_ready;
                @(negedge clk);
                accepted = ready_now;
            end
        end
        set_lane(lane, '0, 1'b0);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial
    begin : main_seq
        int         lane;
        int         pkt;
        int         b;
        int         len;
        int         gap;
        lane_beat_t beat;
        clk       = 1'b0;
        reset     = 1'b1;
        in0_data  = '0;
        in0_last  = 1'b0;
        in0_valid = 1'b0;
        in1_data  = '0;
        in1_last  = 1'b0;
        in1_valid = 1'b0;
        out_ready = 1'b0;
        void'($urandom(32'h429f_198a));
        // Packet lists with gaps only after the back-to-back phase
        for (lane = 0; lane < 2; lane++)
        begin
            for (pkt = 0; pkt < PACKETS; pkt++)
            begin
                len = $urandom_range(1, 8);
                gap = (pkt < GAPLESS) ? 0 : $urandom_range(0, 4);
                for (b = 0; b < len; b++)
                begin
                    beat.data = $urandom;
                    beat.last = (b == len - 1);
                    stim_beats[lane].push_back(beat);
                    stim_gap[lane].push_back((b == 0) ? gap : 0);
                    exp_beats[lane].push_back(expected_beat(lane, beat));
                    total_beats++;
                end
            end
        end
        timeout_cycles = total_beats * 20 + 200;
        stim_built     = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // State right after reset
        check_level("lane0_level", lane0_level, 0);
        check_level("lane1_level", lane1_level, 0);
        if (out_valid !== 1'b0)
            abort_run("out_valid is high right after reset");
        if (in0_ready !== 1'b1 || in1_ready !== 1'b1)
            abort_run("An input ready is low right after reset");
        fork
            send_packets(0);
            send_packets(1);
        join
        // Every expected beat has to leave the merger
        while (exp_beats[0].size() != 0 || exp_beats[1].size() != 0)
            @(negedge clk);
        repeat (4) @(negedge clk);
        // Buffers and output stage empty once the last beat left
        check_level("lane0_level", lane0_level, 0);
        check_level("lane1_level", lane1_level, 0);
        if (out_valid !== 1'b0)
            abort_run("out_valid still high after every expected beat left");
        else
        begin
            $display("TB PASSED");
            $finish;
        end
    end

    // Random output stalls and a compare on each transfer
    initial
    begin : output_side
        merged_beat_t got;
        logic         ready_bit;
        wait (reset === 1'b0);
        forever
        begin
            ready_bit = ($urandom_range(0, 9) >= 3);
            out_ready = ready_bit;
            check_level("lane0_level", lane0_level, 2);
            check_level("lane1_level", lane1_level, 16);
            if (out_valid && ready_bit)
            begin
                got.src       = out_src;
                got.beat.data = out_data;
                got.beat.last = out_last;
                handle_output(got);
            end
            @(negedge clk);
        end
    end

    initial
    begin : watchdog
        wait (stim_built);
        repeat (timeout_cycles) @(posedge clk);
        abort_run($sformatf("Timeout: the merged stream did not drain within %0d cycles",
                            timeout_cycles));
    end

endmodule

//--- sim/stream_merge_properties.sv
/*
 * Stream merger checks
 * Concurrent assertions bound into stream_merge: output hold under
 * stall, packet-atomic grant, and no output valid during reset
 */

`timescale 1ns/100ps

module stream_merge_properties
    import stream_pkg::*;
(
    input logic         clk,
    input logic         reset,
    input logic         out_valid,
    input logic         out_stall,
    input logic         take,
    input logic         take_last,
    input logic         grant_active,
    input logic         grant_lane,
    input merged_beat_t out_beat
);

    // Held beat stays put while the sink stalls
    assert property (@(posedge clk) disable iff (reset)
        out_valid && out_stall |=> out_valid && $stable(out_beat))
        else $error("merged beat changed while the output was stalled");

    // Grant only moves once the last beat of a packet is taken
    assert property (@(posedge clk) disable iff (reset)
        grant_active && !(take && take_last) |=> grant_active && $stable(grant_lane))
        else $error("lane grant changed in the middle of a packet");

    // Output register cleared by reset
    assert property (@(posedge clk) reset |=> !out_valid)
        else $error("merged valid high during reset");

endmodule

bind stream_merge stream_merge_properties merge_props_i (
    .clk          (clk),
    .reset        (reset),
    .out_valid    (out_valid_q),
    .out_stall    (!load_ok),
    .take         (take),
    .take_last    (sel_beat.last),
    .grant_active (grant_active),
    .grant_lane   (grant_lane),
    .out_beat     (out_beat_q)
);
